//--- Makefile
TOP = sq_recv_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal -Ilogic -f sq_recv_cfg.f \
		--top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- logic/hcmd_entry_capture.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module hcmd_entry_capture
	import sq_recv_pkg::*;
(
	input wire logic pcie_user_clk,
	input wire logic w_sq_rst_n,
	input wire logic [`SQ_ENTRY_W-1:0] rx_fifo_data,
	input wire logic entry_load,
	input wire logic [`SQ_BEAT_SEL_W-1:0] beat_sel,
	input wire logic beat_wr_en,
	input wire sq_cmd_t cur_cmd,
	output table_wr_t hcmd_table_wr,
	output cid_wr_t hcmd_cid_wr
);

	logic [`SQ_NUM_BEATS-1:0][`SQ_BEAT_W-1:0] entry_q;
	logic [`SQ_NUM_BEATS-1:0][`SQ_BEAT_W-1:0] entry_src;
	logic tbl_en_q;
	logic [`SQ_SLOT_TAG_W+`SQ_BEAT_SEL_W-1:0] tbl_addr_q;
	logic [`SQ_BEAT_W-1:0] tbl_data_q;
	logic cid_en_q;
	logic [`SQ_SLOT_TAG_W-1:0] cid_addr_q;
	logic [`SQ_QID_W+`SQ_CID_W-1:0] cid_data_q;
	logic cid_sel;

	// beat 0 comes straight off the rx fifo in the load cycle
	assign entry_src = entry_load ? rx_fifo_data : entry_q;
	assign cid_sel = beat_wr_en && (beat_sel == 2'd0);

	always_ff @(posedge pcie_user_clk) begin
		if (entry_load) begin
			entry_q <= rx_fifo_data;
		end
	end

	always_ff @(posedge pcie_user_clk or negedge w_sq_rst_n) begin
		if (!w_sq_rst_n) begin
			tbl_en_q <= 1'b0;
			cid_en_q <= 1'b0;
		end else begin
			tbl_en_q <= beat_wr_en;
			cid_en_q <= cid_sel; // once per command
		end
	end

	always_ff @(posedge pcie_user_clk) begin
		if (beat_wr_en) begin
			tbl_addr_q <= {cur_cmd.slot_tag, beat_sel};
			tbl_data_q <= entry_src[beat_sel];
		end
		if (cid_sel) begin
			cid_addr_q <= cur_cmd.slot_tag;
			cid_data_q <= {cur_cmd.qid, entry_src[0][`SQ_CID_LSB +: `SQ_CID_W]};
		end
	end

	assign hcmd_table_wr = '{wr_en: tbl_en_q, addr: tbl_addr_q, data: tbl_data_q};
	assign hcmd_cid_wr = '{wr_en: cid_en_q, addr: cid_addr_q, data: cid_data_q};

endmodule

`default_nettype wire

//--- logic/hcmd_recv_seq.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module hcmd_recv_seq
	import sq_recv_pkg::*;
(
	input wire logic pcie_user_clk,
	input wire logic w_sq_rst_n,
	input wire logic cmd_fifo_empty_n,
	input wire sq_cmd_t cmd_fifo_data,
	input wire logic rx_fifo_empty_n,
	input wire logic hcmd_sq_full_n,
	output logic cmd_fifo_rd_en,
	output logic rx_fifo_rd_en,
	output logic entry_load,
	output logic [`SQ_BEAT_SEL_W-1:0] beat_sel,
	output logic beat_wr_en,
	output sq_cmd_t cur_cmd,
	output logic hcmd_sq_wr_en,
	output sq_done_t hcmd_sq_wr_data,
	output logic ptr_advance,
	output logic [`SQ_QID_W-1:0] adv_qid
);

	recv_state_e state;
	recv_state_e next_state;
	logic [`SQ_CMD_NUM_W-1:0] hcmd_num;

	always_ff @(posedge pcie_user_clk or negedge w_sq_rst_n) begin
		if (!w_sq_rst_n) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle: begin
				if (cmd_fifo_empty_n) begin
					next_state = s_cmd_pop;
				end
			end
			s_cmd_pop: next_state = s_wait_entry;
			s_wait_entry: begin
				if (rx_fifo_empty_n) begin
					next_state = s_load;
				end
			end
			s_load: next_state = s_beat0;
			s_beat0: next_state = s_beat1;
			s_beat1: next_state = s_beat2;
			s_beat2: next_state = s_beat3;
			s_beat3: next_state = s_wait_sq;
			s_wait_sq: begin
				if (hcmd_sq_full_n) begin // slot queue has room
					next_state = s_done;
				end
			end
			s_done: next_state = s_idle;
			default: next_state = s_idle;
		endcase
	end

	// shown word is valid in the pop cycle
	always_ff @(posedge pcie_user_clk) begin
		if (state == s_cmd_pop) begin
			cur_cmd <= cmd_fifo_data;
		end
	end

	always_ff @(posedge pcie_user_clk or negedge w_sq_rst_n) begin
		if (!w_sq_rst_n) begin
			hcmd_num <= '0;
		end else if (state == s_done) begin
			hcmd_num <= hcmd_num + 1'b1; // wraps at 256
		end
	end

	// table beats are issued one cycle ahead, capture registers them
	always_comb begin
		cmd_fifo_rd_en = 1'b0;
		rx_fifo_rd_en = 1'b0;
		entry_load = 1'b0;
		beat_sel = 2'd0;
		beat_wr_en = 1'b0;
		hcmd_sq_wr_en = 1'b0;
		ptr_advance = 1'b0;
		case (state)
			s_cmd_pop: cmd_fifo_rd_en = 1'b1;
			s_load: begin
				rx_fifo_rd_en = 1'b1;
				entry_load = 1'b1;
				beat_wr_en = 1'b1;
			end
			s_beat0: begin
				beat_sel = 2'd1;
				beat_wr_en = 1'b1;
			end
			s_beat1: begin
				beat_sel = 2'd2;
				beat_wr_en = 1'b1;
			end
			s_beat2: begin
				beat_sel = 2'd3;
				beat_wr_en = 1'b1;
			end
			s_done: begin
				hcmd_sq_wr_en = 1'b1;
				ptr_advance = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign hcmd_sq_wr_data = '{cmd_num: hcmd_num, slot_tag: cur_cmd.slot_tag, qid: cur_cmd.qid};
	assign adv_qid = cur_cmd.qid;

endmodule

`default_nettype wire

//--- logic/sq_head_ptr_array.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module sq_head_ptr_array
	import sq_recv_pkg::*;
(
	input wire logic pcie_user_clk,
	input wire logic w_sq_rst_n,
	input wire logic [`SQ_NUM_QUEUES-1:0] sq_rst_n,
	input wire ptr_vec_t sq_sizes,
	input wire logic ptr_advance,
	input wire logic [`SQ_QID_W-1:0] adv_qid,
	output wire ptr_vec_t head_ptrs
);

	genvar i;

	// queue 0 is admin, 1..8 are io queues
	generate
		for (i = 0; i < `SQ_NUM_QUEUES; i++) begin : g_queue
			logic q_rst_n;
			logic q_adv;
			logic [`SQ_PTR_W-1:0] ptr_q;

			assign q_rst_n = w_sq_rst_n & sq_rst_n[i]; // per-queue clear from software
			assign q_adv = ptr_advance && (adv_qid == `SQ_QID_W'(i));

			always_ff @(posedge pcie_user_clk or negedge q_rst_n) begin
				if (!q_rst_n) begin
					ptr_q <= '0;
				end else if (q_adv) begin
					if (ptr_q == sq_sizes[i]) begin
						ptr_q <= '0; // size is last valid index
					end else begin
						ptr_q <= ptr_q + 1'b1;
					end
				end
			end

			assign head_ptrs[i] = ptr_q;
		end
	endgenerate

endmodule

`default_nettype wire

//--- logic/sq_recv_cfg.svh
`ifndef SQ_RECV_CFG_SVH
`define SQ_RECV_CFG_SVH

// command fifo word
`define SQ_SLOT_TAG_W 10
`define SQ_QID_W 4

// admin queue plus eight io queues
`define SQ_NUM_QUEUES 9
`define SQ_PTR_W 8

// host command entry and table beats
`define SQ_ENTRY_W 512
`define SQ_BEAT_W 128
`define SQ_NUM_BEATS 4
`define SQ_BEAT_SEL_W 2

// command id sits in dword 0 of the entry
`define SQ_CID_W 16
`define SQ_CID_LSB 16

`define SQ_CMD_NUM_W 8

`endif

//--- logic/sq_recv_pkg.sv
`default_nettype none
`include "sq_recv_cfg.svh"

package sq_recv_pkg;

	typedef enum logic [3:0] {
		s_idle,
		s_cmd_pop,
		s_wait_entry,
		s_load, // rx pop, beat 0 selected
		s_beat0,
		s_beat1,
		s_beat2,
		s_beat3,
		s_wait_sq,
		s_done // completion post
	} recv_state_e;

	typedef struct packed {
		logic [`SQ_QID_W-1:0] qid;
		logic [`SQ_SLOT_TAG_W-1:0] slot_tag;
	} sq_cmd_t;

	typedef struct packed {
		logic wr_en;
		logic [`SQ_SLOT_TAG_W+`SQ_BEAT_SEL_W-1:0] addr; // slot tag, beat index
		logic [`SQ_BEAT_W-1:0] data;
	} table_wr_t;

	typedef struct packed {
		logic wr_en;
		logic [`SQ_SLOT_TAG_W-1:0] addr;
		logic [`SQ_QID_W+`SQ_CID_W-1:0] data; // qid, cid
	} cid_wr_t;

	typedef struct packed {
		logic [`SQ_CMD_NUM_W-1:0] cmd_num;
		logic [`SQ_SLOT_TAG_W-1:0] slot_tag;
		logic [`SQ_QID_W-1:0] qid;
	} sq_done_t;

	typedef logic [`SQ_NUM_QUEUES-1:0][`SQ_PTR_W-1:0] ptr_vec_t;

endpackage

`default_nettype wire

//--- logic/sq_recv_top.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module sq_recv_top
	import sq_recv_pkg::*;
(
	input wire logic pcie_user_clk,
	input wire logic w_sq_rst_n,

	input wire sq_cmd_t cmd_fifo_data,
	input wire logic cmd_fifo_empty_n,
	output logic cmd_fifo_rd_en,

	input wire logic [`SQ_ENTRY_W-1:0] rx_fifo_data,
	input wire logic rx_fifo_empty_n,
	output logic rx_fifo_rd_en,

	output table_wr_t hcmd_table_wr,
	output cid_wr_t hcmd_cid_wr,

	output logic hcmd_sq_wr_en,
	output sq_done_t hcmd_sq_wr_data,
	input wire logic hcmd_sq_full_n,

	input wire logic [`SQ_NUM_QUEUES-1:0] sq_rst_n,
	input wire ptr_vec_t sq_sizes,
	output ptr_vec_t head_ptrs
);

	logic entry_load;
	logic [`SQ_BEAT_SEL_W-1:0] beat_sel;
	logic beat_wr_en;
	sq_cmd_t cur_cmd;
	logic ptr_advance;
	logic [`SQ_QID_W-1:0] adv_qid;

	hcmd_recv_seq i_hcmd_recv_seq (
		.pcie_user_clk (pcie_user_clk),
		.w_sq_rst_n (w_sq_rst_n),
		.cmd_fifo_empty_n (cmd_fifo_empty_n),
		.cmd_fifo_data (cmd_fifo_data),
		.rx_fifo_empty_n (rx_fifo_empty_n),
		.hcmd_sq_full_n (hcmd_sq_full_n),
		.cmd_fifo_rd_en (cmd_fifo_rd_en),
		.rx_fifo_rd_en (rx_fifo_rd_en),
		.entry_load (entry_load),
		.beat_sel (beat_sel),
		.beat_wr_en (beat_wr_en),
		.cur_cmd (cur_cmd),
		.hcmd_sq_wr_en (hcmd_sq_wr_en),
		.hcmd_sq_wr_data (hcmd_sq_wr_data),
		.ptr_advance (ptr_advance),
		.adv_qid (adv_qid)
	);

	hcmd_entry_capture i_hcmd_entry_capture (
		.pcie_user_clk (pcie_user_clk),
		.w_sq_rst_n (w_sq_rst_n),
		.rx_fifo_data (rx_fifo_data),
		.entry_load (entry_load),
		.beat_sel (beat_sel),
		.beat_wr_en (beat_wr_en),
		.cur_cmd (cur_cmd),
		.hcmd_table_wr (hcmd_table_wr),
		.hcmd_cid_wr (hcmd_cid_wr)
	);

	sq_head_ptr_array i_sq_head_ptr_array (
		.pcie_user_clk (pcie_user_clk),
		.w_sq_rst_n (w_sq_rst_n),
		.sq_rst_n (sq_rst_n),
		.sq_sizes (sq_sizes),
		.ptr_advance (ptr_advance),
		.adv_qid (adv_qid),
		.head_ptrs (head_ptrs)
	);

endmodule

`default_nettype wire

//--- sq_recv_cfg.f
+incdir+logic
logic/sq_recv_pkg.sv
logic/hcmd_entry_capture.sv
logic/hcmd_recv_seq.sv
logic/sq_head_ptr_array.sv
logic/sq_recv_top.sv
testbench/sq_recv_assert.sv
testbench/sq_recv_tb.sv

//--- testbench/sq_recv_assert.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module sq_recv_assert
	import sq_recv_pkg::*;
(
	input wire logic pcie_user_clk,
	input wire logic w_sq_rst_n,
	input wire logic cmd_fifo_rd_en,
	input wire logic rx_fifo_rd_en,
	input wire table_wr_t hcmd_table_wr,
	input wire cid_wr_t hcmd_cid_wr,
	input wire logic hcmd_sq_wr_en
);

	cmd_pop_pulse: assert property (@(posedge pcie_user_clk) disable iff (!w_sq_rst_n)
		cmd_fifo_rd_en |=> !cmd_fifo_rd_en)
		else $error("cmd_fifo_rd_en held for more than one cycle");

	rx_pop_pulse: assert property (@(posedge pcie_user_clk) disable iff (!w_sq_rst_n)
		rx_fifo_rd_en |=> !rx_fifo_rd_en)
		else $error("rx_fifo_rd_en held for more than one cycle");

	// a run of table writes is exactly four beats
	table_run_of_four: assert property (@(posedge pcie_user_clk) disable iff (!w_sq_rst_n)
		$rose(hcmd_table_wr.wr_en) |=> hcmd_table_wr.wr_en ##1 hcmd_table_wr.wr_en
			##1 hcmd_table_wr.wr_en ##1 !hcmd_table_wr.wr_en)
		else $error("table write run is not four cycles long");

	quiet_in_reset: assert property (@(posedge pcie_user_clk)
		!w_sq_rst_n |-> !cmd_fifo_rd_en && !rx_fifo_rd_en && !hcmd_table_wr.wr_en
			&& !hcmd_cid_wr.wr_en && !hcmd_sq_wr_en)
		else $error("enable output active during reset");

endmodule

bind sq_recv_top sq_recv_assert i_sq_recv_assert (
	.pcie_user_clk (pcie_user_clk),
	.w_sq_rst_n (w_sq_rst_n),
	.cmd_fifo_rd_en (cmd_fifo_rd_en),
	.rx_fifo_rd_en (rx_fifo_rd_en),
	.hcmd_table_wr (hcmd_table_wr),
	.hcmd_cid_wr (hcmd_cid_wr),
	.hcmd_sq_wr_en (hcmd_sq_wr_en)
);

`default_nettype wire

//--- testbench/sq_recv_tb.sv
`default_nettype none
`include "sq_recv_cfg.svh"

module sq_recv_tb
	import sq_recv_pkg::*;
();

	localparam int NUM_CMDS = 300;
	localparam int HALF_PERIOD = 10;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 60 + 500;

	logic pcie_user_clk = 1'b0;
	logic w_sq_rst_n;
	sq_cmd_t cmd_fifo_data;
	logic cmd_fifo_empty_n;
	logic cmd_fifo_rd_en;
	logic [`SQ_ENTRY_W-1:0] rx_fifo_data;
	logic rx_fifo_empty_n;
	logic rx_fifo_rd_en;
	table_wr_t hcmd_table_wr;
	cid_wr_t hcmd_cid_wr;
	logic hcmd_sq_wr_en;
	sq_done_t hcmd_sq_wr_data;
	logic hcmd_sq_full_n;
	logic [`SQ_NUM_QUEUES-1:0] sq_rst_n;
	ptr_vec_t sq_sizes;
	ptr_vec_t head_ptrs;

	sq_cmd_t cmd_q[$]; // fifo contents
	logic [`SQ_ENTRY_W-1:0] rx_q[$];
	sq_cmd_t exp_cmd_q[$]; // commands not yet completed
	logic [`SQ_ENTRY_W-1:0] exp_entry_q[$];

	int errors;
	int cmds_sent;
	int entries_sent;
	int cmd_pops;
	int rx_pops;
	int table_beats;
	int cid_writes;
	int done_count;
	int cycle;
	logic pop_cmd;
	logic pop_rx;
	logic prev_full_n;
	logic prev_adv;
	logic [`SQ_QID_W-1:0] prev_adv_qid;
	logic [`SQ_NUM_QUEUES-1:0] prev_rst_n;
	ptr_vec_t exp_ptrs;

	sq_recv_top i_sq_recv_top (
		.pcie_user_clk (pcie_user_clk),
		.w_sq_rst_n (w_sq_rst_n),
		.cmd_fifo_data (cmd_fifo_data),
		.cmd_fifo_empty_n (cmd_fifo_empty_n),
		.cmd_fifo_rd_en (cmd_fifo_rd_en),
		.rx_fifo_data (rx_fifo_data),
		.rx_fifo_empty_n (rx_fifo_empty_n),
		.rx_fifo_rd_en (rx_fifo_rd_en),
		.hcmd_table_wr (hcmd_table_wr),
		.hcmd_cid_wr (hcmd_cid_wr),
		.hcmd_sq_wr_en (hcmd_sq_wr_en),
		.hcmd_sq_wr_data (hcmd_sq_wr_data),
		.hcmd_sq_full_n (hcmd_sq_full_n),
		.sq_rst_n (sq_rst_n),
		.sq_sizes (sq_sizes),
		.head_ptrs (head_ptrs)
	);

	// reference model of the command path
	function automatic logic [`SQ_SLOT_TAG_W+1:0] ref_table_addr(sq_cmd_t c, int k);
		logic [`SQ_SLOT_TAG_W+1:0] a;
		a = `SQ_SLOT_TAG_W'(c.slot_tag) * 4 + k; // slot x 4 + beat
		return a;
	endfunction

	function automatic logic [`SQ_BEAT_W-1:0] ref_beat(logic [`SQ_ENTRY_W-1:0] e, int k);
		return e[k*`SQ_BEAT_W +: `SQ_BEAT_W];
	endfunction

	function automatic logic [`SQ_QID_W+`SQ_CID_W-1:0] ref_cid(sq_cmd_t c,
			logic [`SQ_ENTRY_W-1:0] e);
		return {c.qid, e[31:16]};
	endfunction

	function automatic sq_done_t ref_done(sq_cmd_t c, int num);
		sq_done_t d;
		d.cmd_num = num[7:0]; // wraps at 256
		d.slot_tag = c.slot_tag;
		d.qid = c.qid;
		return d;
	endfunction

	function automatic logic [`SQ_PTR_W-1:0] ref_next_ptr(logic [`SQ_PTR_W-1:0] p,
			logic [`SQ_PTR_W-1:0] size);
		if (p == size) begin
			return '0;
		end
		return p + 8'd1;
	endfunction

	function automatic logic [`SQ_ENTRY_W-1:0] random_entry();
		logic [`SQ_ENTRY_W-1:0] e;
		for (int w = 0; w < `SQ_ENTRY_W / 32; w++) begin
			e[w*32 +: 32] = $urandom;
		end
		return e;
	endfunction

	function automatic sq_cmd_t random_cmd();
		sq_cmd_t c;
		int q;
		int s;
		q = $urandom % 11; // 9 and 10 are out of range
		s = $urandom % 1024;
		c.qid = q[3:0];
		c.slot_tag = s[9:0];
		return c;
	endfunction

	task automatic report_mismatch(string msg);
		$display("FAIL t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic report_problem(string msg);
		$display("problem at time %0t: %s", $time, msg);
		errors++;
	endtask

	initial begin
		forever #(HALF_PERIOD) pcie_user_clk = ~pcie_user_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
		$display("timeout: only %0d of %0d commands completed", done_count, NUM_CMDS);
		$display("CHECKS FAILED");
		$finish;
	end

	// fifo models, slot queue back-pressure and queue resets
	task automatic drive_cycle();
		sq_cmd_t c;
		logic [`SQ_ENTRY_W-1:0] e;
		int full_hold;
		full_hold = 0;
		forever begin
			@(posedge pcie_user_clk);
			#2;
			cycle++;
			if (pop_cmd && cmd_q.size() > 0) begin
				c = cmd_q.pop_front();
			end
			if (pop_rx && rx_q.size() > 0) begin
				e = rx_q.pop_front();
			end
			if (cmds_sent < NUM_CMDS && ($urandom % 4) == 0) begin
				c = random_cmd();
				cmd_q.push_back(c);
				exp_cmd_q.push_back(c);
				cmds_sent++;
			end
			if (entries_sent < cmds_sent && ($urandom % 6) == 0) begin
				e = random_entry();
				rx_q.push_back(e);
				exp_entry_q.push_back(e);
				entries_sent++;
			end
			if (full_hold > 0) begin
				full_hold--;
			end else begin
				full_hold = $urandom % 8;
				hcmd_sq_full_n = ($urandom % 3) != 0;
			end
			if ((cycle % 150) == 75) begin
				sq_rst_n = ~(9'd1 << ($urandom % `SQ_NUM_QUEUES)); // clear one queue
			end else begin
				sq_rst_n = '1;
			end
			cmd_fifo_empty_n = cmd_q.size() > 0;
			cmd_fifo_data = (cmd_q.size() > 0) ? cmd_q[0] : '0;
			rx_fifo_empty_n = rx_q.size() > 0;
			rx_fifo_data = (rx_q.size() > 0) ? rx_q[0] : '0;
		end
	endtask

	// compare process, outputs are stable at the falling edge
	always @(negedge pcie_user_clk) begin
		pop_cmd = cmd_fifo_rd_en;
		pop_rx = rx_fifo_rd_en;
		for (int i = 0; i < `SQ_NUM_QUEUES; i++) begin
			if (!w_sq_rst_n || !sq_rst_n[i]) begin
				exp_ptrs[i] = '0;
			end else if (prev_adv && prev_adv_qid == i && prev_rst_n[i]) begin
				exp_ptrs[i] = ref_next_ptr(exp_ptrs[i], sq_sizes[i]);
			end
			if (head_ptrs[i] !== exp_ptrs[i]) begin
				report_mismatch($sformatf("head ptr %0d is %0d, expected %0d",
					i, head_ptrs[i], exp_ptrs[i]));
			end
		end
		prev_adv = 1'b0;
		if (w_sq_rst_n) begin
			if (cmd_fifo_rd_en) begin
				cmd_pops++;
				if (!cmd_fifo_empty_n) begin
					report_problem("command fifo read while empty");
				end
			end
			if (rx_fifo_rd_en) begin
				rx_pops++;
				if (!rx_fifo_empty_n) begin
					report_problem("receive fifo read while empty");
				end
				if (rx_pops > cmd_pops) begin
					report_problem("entry read without a command");
				end
			end
			if (hcmd_table_wr.wr_en) begin
				if (exp_cmd_q.size() == 0 || table_beats / 4 >= rx_pops) begin
					report_problem("table write without a received entry");
				end else begin
					if (hcmd_table_wr.addr !== ref_table_addr(exp_cmd_q[0], table_beats % 4)) begin
						report_mismatch($sformatf("table addr %h, expected %h", hcmd_table_wr.addr,
							ref_table_addr(exp_cmd_q[0], table_beats % 4)));
					end
					if (hcmd_table_wr.data !== ref_beat(exp_entry_q[0], table_beats % 4)) begin
						report_mismatch($sformatf("table data beat %0d wrong", table_beats % 4));
					end
				end
				table_beats++;
			end
			if (hcmd_cid_wr.wr_en) begin
				cid_writes++;
				if (exp_cmd_q.size() == 0 || cid_writes > rx_pops) begin
					report_problem("command id write without a received entry");
				end else begin
					if (hcmd_cid_wr.addr !== exp_cmd_q[0].slot_tag) begin
						report_mismatch($sformatf("cid addr %h, expected %h",
							hcmd_cid_wr.addr, exp_cmd_q[0].slot_tag));
					end
					if (hcmd_cid_wr.data !== ref_cid(exp_cmd_q[0], exp_entry_q[0])) begin
						report_mismatch($sformatf("cid data %h, expected %h", hcmd_cid_wr.data,
							ref_cid(exp_cmd_q[0], exp_entry_q[0])));
					end
				end
			end
			if (hcmd_sq_wr_en) begin
				if (!prev_full_n) begin
					report_problem("completion posted while the slot queue was full");
				end
				if (exp_cmd_q.size() == 0 || table_beats != 4 * (done_count + 1)) begin
					report_problem("completion without four table beats");
				end else begin
					if (hcmd_sq_wr_data !== ref_done(exp_cmd_q[0], done_count)) begin
						report_mismatch($sformatf("completion %h, expected %h", hcmd_sq_wr_data,
							ref_done(exp_cmd_q[0], done_count)));
					end
					prev_adv = 1'b1;
					prev_adv_qid = exp_cmd_q[0].qid;
					exp_cmd_q.delete(0);
					exp_entry_q.delete(0);
				end
				done_count++;
			end
		end
		prev_full_n = hcmd_sq_full_n;
		prev_rst_n = sq_rst_n;
	end

	initial begin
		void'($urandom(32'h9365_1845));
		errors = 0;
		cmds_sent = 0;
		entries_sent = 0;
		cmd_pops = 0;
		rx_pops = 0;
		table_beats = 0;
		cid_writes = 0;
		done_count = 0;
		cycle = 0;
		pop_cmd = 1'b0;
		pop_rx = 1'b0;
		prev_full_n = 1'b0;
		prev_adv = 1'b0;
		prev_adv_qid = '0;
		prev_rst_n = '1;
		exp_ptrs = '0;
		w_sq_rst_n = 1'b0;
		cmd_fifo_data = '0;
		cmd_fifo_empty_n = 1'b0;
		rx_fifo_data = '0;
		rx_fifo_empty_n = 1'b0;
		hcmd_sq_full_n = 1'b1;
		sq_rst_n = '1;
		for (int i = 0; i < `SQ_NUM_QUEUES; i++) begin
			sq_sizes[i] = 8'd3 + 8'($urandom % 4); // small so pointers wrap
		end
		repeat (5) @(posedge pcie_user_clk);
		#2;
		w_sq_rst_n = 1'b1;
		fork
			drive_cycle();
		join_none
		while (done_count < NUM_CMDS) begin
			@(posedge pcie_user_clk);
		end
		repeat (20) @(posedge pcie_user_clk);
		if (cmd_pops != NUM_CMDS || cid_writes != NUM_CMDS || table_beats != 4 * NUM_CMDS) begin
			report_problem("strobe counts do not match the number of commands");
		end
		$display("summary: %0d commands, %0d pops, %0d beats, %0d cid writes, %0d errors",
			done_count, cmd_pops, table_beats, cid_writes, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
